//--- Makefile
TOP = tb_io_serdes

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- io_serdes.sv
`default_nettype none

module io_serdes #(
  parameter int data_width = 32
) (
  input  logic                                  ioclk,
  input  logic                                  axis_rst_n,
  // register port
  input  logic                                  cc_is_enable,
  input  logic                                  axi_awvalid,
  input  logic [14:0]                           axi_awaddr,
  output logic                                  axi_awready,
  input  logic                                  axi_wvalid,
  input  logic [data_width-1:0]                 axi_wdata,
  input  logic [data_width/8-1:0]               axi_wstrb,
  output logic                                  axi_wready,
  input  logic                                  axi_arvalid,
  input  logic [14:0]                           axi_araddr,
  output logic                                  axi_arready,
  output logic                                  axi_rvalid,
  output logic [data_width-1:0]                 axi_rdata,
  input  logic                                  axi_rready,
  // transmit stream
  input  logic [data_width-1:0]                 as_is_tdata,
  input  logic [data_width/8-1:0]               as_is_tstrb,
  input  logic [data_width/8-1:0]               as_is_tkeep,
  input  logic [1:0]                            as_is_tid,
  input  logic [1:0]                            as_is_tuser,
  input  logic                                  as_is_tlast,
  input  logic                                  as_is_tvalid,
  input  logic                                  as_is_tready,
  // serial link
  output logic [serdes_link_pkg::num_lanes-1:0] serial_txd,
  input  logic [serdes_link_pkg::num_lanes-1:0] serial_rxd,
  // receive stream
  output logic [data_width-1:0]                 is_as_tdata,
  output logic [data_width/8-1:0]               is_as_tstrb,
  output logic [data_width/8-1:0]               is_as_tkeep,
  output logic [1:0]                            is_as_tid,
  output logic [1:0]                            is_as_tuser,
  output logic                                  is_as_tlast,
  output logic                                  is_as_tvalid,
  output logic                                  is_as_tready
);
  import serdes_link_pkg::*;

  localparam int clk_ratio = data_width / 8;

  logic                           rxen_ctl;
  logic                           txen_ctl;
  logic [$clog2(clk_ratio)-1:0]   phase;
  logic                           beat_end;
  logic                           txen;
  logic                           rxen;
  logic                           rx_received;
  logic [num_lanes*clk_ratio-1:0] lane_words;
  logic [num_lanes-1:0]           lane_valid;

  serdes_ctrl_regs #(.data_width(data_width)) u_ctrl_regs (
    .ioclk, .axis_rst_n, .cc_is_enable,
    .axi_awvalid, .axi_awaddr, .axi_awready,
    .axi_wvalid, .axi_wdata, .axi_wstrb, .axi_wready,
    .axi_arvalid, .axi_araddr, .axi_arready,
    .axi_rvalid, .axi_rdata, .axi_rready,
    .rxen_ctl, .txen_ctl
  );

  serdes_beat_phase #(.data_width(data_width)) u_beat_phase (
    .ioclk, .axis_rst_n, .rxen_ctl, .txen_ctl, .rx_received,
    .phase, .beat_end, .txen, .rxen
  );

  serdes_tx_serializer #(.data_width(data_width)) u_tx_serializer (
    .ioclk, .axis_rst_n, .phase, .beat_end, .txen, .is_as_tready,
    .as_is_tdata, .as_is_tstrb, .as_is_tkeep, .as_is_tid, .as_is_tuser,
    .as_is_tlast, .as_is_tvalid, .as_is_tready,
    .serial_txd
  );

  // one deserializer per lane
  for (genvar l = 0; l < num_lanes; l++) begin : g_lane
    serdes_rx_lane #(.data_width(data_width)) u_rx_lane (
      .ioclk, .axis_rst_n, .rxen, .phase,
      .serial_bit (serial_rxd[l]),
      .lane_word  (lane_words[l*clk_ratio +: clk_ratio]),
      .word_valid (lane_valid[l])
    );
  end

  serdes_rx_beat_assemble #(.data_width(data_width)) u_rx_assemble (
    .ioclk, .axis_rst_n, .txen, .lane_words,
    .word_valid (lane_valid[0]),
    .is_as_tdata, .is_as_tstrb, .is_as_tkeep, .is_as_tid, .is_as_tuser,
    .is_as_tlast, .is_as_tvalid, .is_as_tready, .rx_received
  );

endmodule

`default_nettype wire

//--- serdes_beat_phase.sv
`default_nettype none

module serdes_beat_phase #(
  parameter int data_width = 32
) (
  input  logic                            ioclk,
  input  logic                            axis_rst_n,
  input  logic                            rxen_ctl,
  input  logic                            txen_ctl,
  input  logic                            rx_received,
  output logic [$clog2(data_width/8)-1:0] phase,
  output logic                            beat_end,
  output logic                            txen,
  output logic                            rxen
);
  import serdes_reg_pkg::*;

  localparam int clk_ratio = data_width / 8;
  localparam int phase_w   = $clog2(clk_ratio);

  link_state_e state;
  link_state_e state_nxt;

  //////////////////////////////////////////////////////////////////////
  // beat phase, one beat = clk_ratio ioclk cycles
  //////////////////////////////////////////////////////////////////////

  assign beat_end = (phase == phase_w'(clk_ratio - 1));

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      phase <= '0;
    end else if (beat_end) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  // receiver enable, sticky
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rxen <= 1'b0;
    end else if (rxen_ctl) begin
      rxen <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // transmitter release
  //////////////////////////////////////////////////////////////////////

  // remote traffic also arms the transmitter, so the remote side gets our ready
  always_comb begin
    state_nxt = state;
    case (state)
      link_idle:  if (txen_ctl || rx_received) state_nxt = link_armed;
      link_armed: if (beat_end) state_nxt = link_run;   // start on a beat boundary
      default:    state_nxt = link_run;
    endcase
  end

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state <= link_idle;
    end else begin
      state <= state_nxt;
    end
  end

  assign txen = (state == link_run);

  a_txen_sticky: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
    txen |=> txen)
    else $error("txen dropped after the link started");

endmodule

`default_nettype wire

//--- serdes_ctrl_regs.sv
`default_nettype none

module serdes_ctrl_regs #(
  parameter int data_width = 32
) (
  input  logic                    ioclk,
  input  logic                    axis_rst_n,
  input  logic                    cc_is_enable,
  input  logic                    axi_awvalid,
  input  logic [14:0]             axi_awaddr,
  output logic                    axi_awready,
  input  logic                    axi_wvalid,
  input  logic [data_width-1:0]   axi_wdata,
  input  logic [data_width/8-1:0] axi_wstrb,
  output logic                    axi_wready,
  input  logic                    axi_arvalid,  // read channel always accepted
  input  logic [14:0]             axi_araddr,   // only one register, not decoded
  output logic                    axi_arready,
  output logic                    axi_rvalid,
  output logic [data_width-1:0]   axi_rdata,
  input  logic                    axi_rready,
  output logic                    rxen_ctl,
  output logic                    txen_ctl
);
  import serdes_reg_pkg::*;

  logic wr_fire;

  // address and data must meet in the same cycle, nothing is buffered
  assign wr_fire     = axi_awvalid & axi_wvalid & cc_is_enable;
  assign axi_awready = wr_fire;
  assign axi_wready  = wr_fire;

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rxen_ctl <= 1'b0;
      txen_ctl <= 1'b0;
    end else if (wr_fire && axi_awaddr[11:2] == reg_ctrl && axi_wstrb[0]) begin
      rxen_ctl <= axi_wdata[ctrl_rxen_bit];
      txen_ctl <= axi_wdata[ctrl_txen_bit];
    end
  end

  // read side is always ready and always valid
  assign axi_arready = 1'b1;
  assign axi_rvalid  = 1'b1;

  always_comb begin
    axi_rdata                = '0;
    axi_rdata[ctrl_rxen_bit] = rxen_ctl;
    axi_rdata[ctrl_txen_bit] = txen_ctl;
  end

  a_aw_w_ready_pair: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
    axi_awready == axi_wready)
    else $error("write address and write data ready split");

endmodule

`default_nettype wire

//--- serdes_link_pkg.sv
`default_nettype none

package serdes_link_pkg;

  //////////////////////////////////////////////////////////////////////
  // lane map of the serial bus
  //////////////////////////////////////////////////////////////////////

  localparam int num_data_lanes = 8;  // tdata lanes, lane d carries tdata[d*ratio +: ratio]
  localparam int num_lanes      = 12; // 8 data + 4 control

  localparam int lane_strb    = 8;
  localparam int lane_keep    = 9;
  localparam int lane_id_user = 10;
  localparam int lane_flow    = 11;

  // bit positions inside the flow lane word
  localparam int flow_tready = 0; // sender's own sink ready, goes back to the remote transmitter
  localparam int flow_tvalid = 1;
  localparam int flow_tlast  = 2;

  // id/user lane word, higher bits are sent as zero
  localparam int idu_tuser_lsb = 0;
  localparam int idu_tid_lsb   = 2;

endpackage

`default_nettype wire

//--- serdes_reg_pkg.sv
`default_nettype none

package serdes_reg_pkg;

  // word offsets, taken from address bits 11:2
  typedef enum logic [9:0] {
    reg_ctrl = 10'h000
  } reg_offset_e;

  // fields of reg_ctrl
  localparam int ctrl_rxen_bit = 0;
  localparam int ctrl_txen_bit = 1;

  // transmitter release sequence
  typedef enum logic [1:0] {
    link_idle,  // transmitter off
    link_armed, // enable seen, waiting for a beat boundary
    link_run    // transmitting every beat period
  } link_state_e;

endpackage

`default_nettype wire

//--- serdes_rx_beat_assemble.sv
`default_nettype none

module serdes_rx_beat_assemble #(
  parameter int data_width = 32
) (
  input  logic                                               ioclk,
  input  logic                                               axis_rst_n,
  input  logic                                               txen,
  input  logic [serdes_link_pkg::num_lanes*(data_width/8)-1:0] lane_words,
  input  logic                                               word_valid,  // lane 0, all lanes agree
  output logic [data_width-1:0]                              is_as_tdata,
  output logic [data_width/8-1:0]                            is_as_tstrb,
  output logic [data_width/8-1:0]                            is_as_tkeep,
  output logic [1:0]                                         is_as_tid,
  output logic [1:0]                                         is_as_tuser,
  output logic                                               is_as_tlast,
  output logic                                               is_as_tvalid,
  output logic                                               is_as_tready,
  output logic                                               rx_received
);
  import serdes_link_pkg::*;

  localparam int clk_ratio = data_width / 8;

  logic [clk_ratio-1:0] flow_word;
  logic [clk_ratio-1:0] idu_word;
  logic                 remote_tready;

  assign flow_word = lane_words[lane_flow*clk_ratio +: clk_ratio];
  assign idu_word  = lane_words[lane_id_user*clk_ratio +: clk_ratio];

  //////////////////////////////////////////////////////////////////////
  // payload fields, held until the next word
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ioclk) begin
    if (word_valid) begin
      for (int d = 0; d < num_data_lanes; d++) begin
        is_as_tdata[d*clk_ratio +: clk_ratio] <= lane_words[d*clk_ratio +: clk_ratio];
      end
      is_as_tstrb <= lane_words[lane_strb*clk_ratio +: clk_ratio];
      is_as_tkeep <= lane_words[lane_keep*clk_ratio +: clk_ratio];
      is_as_tuser <= idu_word[idu_tuser_lsb +: 2];
      is_as_tid   <= idu_word[idu_tid_lsb +: 2];
      is_as_tlast <= flow_word[flow_tlast];
    end
  end

  // tvalid is a single-cycle pulse per received beat
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      is_as_tvalid  <= 1'b0;
      remote_tready <= 1'b0;
      rx_received   <= 1'b0;
    end else begin
      is_as_tvalid <= word_valid & flow_word[flow_tvalid];
      if (word_valid) begin
        remote_tready <= flow_word[flow_tready];
        if (flow_word[flow_tvalid] || flow_word[flow_tready]) begin
          rx_received <= 1'b1;  // remote side is alive
        end
      end
    end
  end

  // ready on our own until the remote side speaks, then follow it
  assign is_as_tready = txen & (~rx_received | remote_tready);

endmodule

`default_nettype wire

//--- serdes_rx_lane.sv
`default_nettype none

module serdes_rx_lane #(
  parameter int data_width = 32
) (
  input  logic                            ioclk,
  input  logic                            axis_rst_n,
  input  logic                            rxen,
  input  logic [$clog2(data_width/8)-1:0] phase,
  input  logic                            serial_bit,
  output logic [data_width/8-1:0]         lane_word,
  output logic                            word_valid
);
  localparam int clk_ratio = data_width / 8;
  localparam int phase_w   = $clog2(clk_ratio);

  logic [phase_w-1:0] slot;

  // link adds one cycle, so the bit seen in phase p+1 belongs at p
  // ratio is a power of two, the subtraction wraps by itself
  assign slot = phase - 1'b1;

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      lane_word <= '0;
    end else if (rxen) begin
      lane_word[slot] <= serial_bit;
    end
  end

  // last bit lands in phase 0, word is complete one cycle later
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= rxen && (phase == '0);
    end
  end

  a_valid_needs_rxen: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
    word_valid |-> rxen)
    else $error("lane word completed with receiver disabled");

endmodule

`default_nettype wire

//--- serdes_tx_serializer.sv
`default_nettype none

module serdes_tx_serializer #(
  parameter int data_width = 32
) (
  input  logic                                ioclk,
  input  logic                                axis_rst_n,
  input  logic [$clog2(data_width/8)-1:0]     phase,
  input  logic                                beat_end,
  input  logic                                txen,
  input  logic                                is_as_tready,  // local ready offered upstream
  input  logic [data_width-1:0]               as_is_tdata,
  input  logic [data_width/8-1:0]             as_is_tstrb,
  input  logic [data_width/8-1:0]             as_is_tkeep,
  input  logic [1:0]                          as_is_tid,
  input  logic [1:0]                          as_is_tuser,
  input  logic                                as_is_tlast,
  input  logic                                as_is_tvalid,
  input  logic                                as_is_tready,  // local sink ready, sent to remote
  output logic [serdes_link_pkg::num_lanes-1:0] serial_txd
);
  import serdes_link_pkg::*;
  import serdes_reg_pkg::*;

  localparam int clk_ratio = data_width / 8;
  localparam link_state_e tx_live = link_run;

  logic [clk_ratio-1:0] lane_in [num_lanes];
  logic [clk_ratio-1:0] beat_q  [num_lanes];

  // spread the stream beat over the lane words
  always_comb begin
    for (int d = 0; d < num_data_lanes; d++) begin
      lane_in[d] = as_is_tdata[d*clk_ratio +: clk_ratio];
    end
    lane_in[lane_strb] = as_is_tstrb;
    lane_in[lane_keep] = as_is_tkeep;

    lane_in[lane_id_user]                        = '0;
    lane_in[lane_id_user][idu_tuser_lsb +: 2]    = as_is_tuser;
    lane_in[lane_id_user][idu_tid_lsb +: 2]      = as_is_tid;

    lane_in[lane_flow]              = '0;
    lane_in[lane_flow][flow_tready] = as_is_tready;
    lane_in[lane_flow][flow_tvalid] = as_is_tvalid & is_as_tready;  // only beats we accepted
    lane_in[lane_flow][flow_tlast]  = as_is_tlast;
  end

  // capture once per beat, at the boundary
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      for (int l = 0; l < num_lanes; l++) begin
        beat_q[l] <= '0;
      end
    end else if (beat_end && txen) begin
      for (int l = 0; l < num_lanes; l++) begin
        beat_q[l] <= lane_in[l];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // serial out, bit k of each word during phase k, one register stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      serial_txd <= '0;
    end else begin
      for (int l = 0; l < num_lanes; l++) begin
        serial_txd[l] <= txen & beat_q[l][phase];
      end
    end
  end

  a_txd_quiet: assert property (@(posedge ioclk) disable iff (!axis_rst_n)
    !txen |-> serial_txd == '0)
    else $error("serial_txd active before link reached %s", tx_live.name());

endmodule

`default_nettype wire

//--- tb_io_serdes.sv
`default_nettype none

module tb_io_serdes;

  localparam int data_width = 32;
  localparam int clk_ratio  = data_width / 8;
  localparam int num_beats  = 24;

  // packed beat holds tdata, tstrb, tkeep, tid, tuser and tlast from bit 0 up
  localparam int off_strb = data_width;
  localparam int off_keep = off_strb + clk_ratio;
  localparam int off_id   = off_keep + clk_ratio;
  localparam int off_user = off_id + 2;
  localparam int off_last = off_user + 2;
  localparam int beat_w   = off_last + 1;

  localparam logic [31:0] seed = 32'd4;

  logic                    ioclk;
  logic                    axis_rst_n;
  logic                    cc_is_enable;
  logic                    axi_awvalid;
  logic [14:0]             axi_awaddr;
  logic                    axi_awready;
  logic                    axi_wvalid;
  logic [data_width-1:0]   axi_wdata;
  logic [clk_ratio-1:0]    axi_wstrb;
  logic                    axi_wready;
  logic                    axi_arvalid;
  logic [14:0]             axi_araddr;
  logic                    axi_arready;
  logic                    axi_rvalid;
  logic [data_width-1:0]   axi_rdata;
  logic                    axi_rready;
  logic [data_width-1:0]   as_is_tdata;
  logic [clk_ratio-1:0]    as_is_tstrb;
  logic [clk_ratio-1:0]    as_is_tkeep;
  logic [1:0]              as_is_tid;
  logic [1:0]              as_is_tuser;
  logic                    as_is_tlast;
  logic                    as_is_tvalid;
  logic                    as_is_tready;
  logic [11:0]             serial_loop;  // txd wired straight back to rxd
  logic [data_width-1:0]   is_as_tdata;
  logic [clk_ratio-1:0]    is_as_tstrb;
  logic [clk_ratio-1:0]    is_as_tkeep;
  logic [1:0]              is_as_tid;
  logic [1:0]              is_as_tuser;
  logic                    is_as_tlast;
  logic                    is_as_tvalid;
  logic                    is_as_tready;

  logic [1:0] tb_phase;
  int         exp_q[$];   // accepted beat indices in send order
  int         next_idx;
  int         rcv_count;
  int         blocked;
  int         errors;
  int         checks;
  int         tests_run;
  int         tests_failed;

  io_serdes #(.data_width(data_width)) dut (
    .ioclk, .axis_rst_n, .cc_is_enable,
    .axi_awvalid, .axi_awaddr, .axi_awready,
    .axi_wvalid, .axi_wdata, .axi_wstrb, .axi_wready,
    .axi_arvalid, .axi_araddr, .axi_arready,
    .axi_rvalid, .axi_rdata, .axi_rready,
    .as_is_tdata, .as_is_tstrb, .as_is_tkeep, .as_is_tid, .as_is_tuser,
    .as_is_tlast, .as_is_tvalid, .as_is_tready,
    .serial_txd (serial_loop),
    .serial_rxd (serial_loop),
    .is_as_tdata, .is_as_tstrb, .is_as_tkeep, .is_as_tid, .is_as_tuser,
    .is_as_tlast, .is_as_tvalid, .is_as_tready
  );

  always #2 ioclk = ~ioclk;

  // beat phase as the link defines it
  always @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      tb_phase <= 2'd0;
    end else if (tb_phase == 2'(clk_ratio - 1)) begin
      tb_phase <= 2'd0;
    end else begin
      tb_phase <= tb_phase + 2'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // n-th accepted beat from two draws per beat
  function automatic logic [beat_w-1:0] ref_beat(input int n);
    logic [31:0]       s;
    logic [31:0]       data;
    logic [31:0]       side;
    logic [beat_w-1:0] b;
    s = seed;
    data = '0;
    side = '0;
    for (int i = 0; i <= n; i++) begin
      s = xorshift(s);
      data = s;
      s = xorshift(s);
      side = s;
    end
    b = '0;
    b[data_width-1:0]       = data;
    b[off_strb +: clk_ratio] = side[0 +: clk_ratio];
    b[off_keep +: clk_ratio] = side[8 +: clk_ratio];
    b[off_id +: 2]          = side[16 +: 2];
    b[off_user +: 2]        = side[20 +: 2];
    b[off_last]             = side[24];
    return b;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, want);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, errors - errors_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers drive on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic reg_write(input logic [14:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic en,
                           output logic aw_ready, output logic w_ready);
    @(negedge ioclk);
    cc_is_enable = en;
    axi_awvalid  = 1'b1;
    axi_wvalid   = 1'b1;
    axi_awaddr   = addr;
    axi_wdata    = data;
    axi_wstrb    = strb;
    @(posedge ioclk);
    aw_ready = axi_awready;  // handshake is combinational
    w_ready  = axi_wready;
    @(negedge ioclk);
    axi_awvalid  = 1'b0;
    axi_wvalid   = 1'b0;
    cc_is_enable = 1'b1;
  endtask

  task automatic drive_beat(input logic [beat_w-1:0] b, input logic valid);
    as_is_tdata  = b[data_width-1:0];
    as_is_tstrb  = b[off_strb +: clk_ratio];
    as_is_tkeep  = b[off_keep +: clk_ratio];
    as_is_tid    = b[off_id +: 2];
    as_is_tuser  = b[off_user +: 2];
    as_is_tlast  = b[off_last];
    as_is_tvalid = valid;
  endtask

  // falling edge just before a beat boundary is taken only with ready high
  task automatic offer_slot();
    logic [beat_w-1:0] b;
    int                n;
    n = 1;
    @(negedge ioclk);
    while (tb_phase != 2'(clk_ratio - 1) && n < 2 * clk_ratio) begin
      @(negedge ioclk);
      n++;
    end
    assert (tb_phase == 2'(clk_ratio - 1)) else report_error("no beat boundary came up");
    b = ref_beat(next_idx);
    if (is_as_tready) begin
      drive_beat(b, 1'b1);
      exp_q.push_back(next_idx);
      next_idx++;
    end else begin
      b[data_width-1:0] = ~b[data_width-1:0];  // decoy that must never arrive
      drive_beat(b, 1'b1);
      blocked++;
    end
  endtask

  task automatic wait_received(input int target, input int max_cycles);
    int n;
    n = 0;
    @(posedge ioclk);
    while (rcv_count < target && n < max_cycles) begin
      @(posedge ioclk);
      n++;
    end
    assert (rcv_count >= target) else report_error("timed out waiting for received beats");
    @(negedge ioclk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare received beats in order
  //////////////////////////////////////////////////////////////////////

  always @(negedge ioclk) begin : compare_beats
    int                idx;
    logic [beat_w-1:0] want;
    if (axis_rst_n && is_as_tvalid) begin
      assert (exp_q.size() != 0) else report_error("beat received with none outstanding");
      if (exp_q.size() != 0) begin
        idx  = exp_q.pop_front();
        want = ref_beat(idx);
        check_val("is_as_tdata", 32'(is_as_tdata), 32'(want[data_width-1:0]));
        check_val("is_as_tstrb", 32'(is_as_tstrb), 32'(want[off_strb +: clk_ratio]));
        check_val("is_as_tkeep", 32'(is_as_tkeep), 32'(want[off_keep +: clk_ratio]));
        check_val("is_as_tid", 32'(is_as_tid), 32'(want[off_id +: 2]));
        check_val("is_as_tuser", 32'(is_as_tuser), 32'(want[off_user +: 2]));
        check_val("is_as_tlast", 32'(is_as_tlast), 32'(want[off_last]));
      end
      rcv_count++;
    end
  end

  initial begin : main
    logic aw_acc;
    logic w_acc;
    int   e0;
    int   n;
    int   target;
    int   mark;
    ioclk        = 1'b0;
    axis_rst_n   = 1'b0;
    cc_is_enable = 1'b1;
    axi_awvalid  = 1'b0;
    axi_awaddr   = '0;
    axi_wvalid   = 1'b0;
    axi_wdata    = '0;
    axi_wstrb    = '0;
    axi_arvalid  = 1'b1;  // reads are always taken
    axi_araddr   = '0;
    axi_rready   = 1'b1;
    as_is_tready = 1'b1;
    drive_beat('0, 1'b0);
    next_idx     = 0;
    rcv_count    = 0;
    blocked      = 0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;

    repeat (2) @(posedge ioclk);
    @(negedge ioclk);
    axis_rst_n = 1'b1;

    // after reset
    e0 = errors;
    check_val("axi_rdata", axi_rdata, 32'd0);
    check_val("is_as_tvalid", 32'(is_as_tvalid), 32'd0);
    check_val("is_as_tready", 32'(is_as_tready), 32'd0);
    check_val("serial_txd", 32'(serial_loop), 32'd0);
    check_val("axi_arready", 32'(axi_arready), 32'd1);
    check_val("axi_rvalid", 32'(axi_rvalid), 32'd1);
    end_test("reset state", e0);

    // ignored register writes first and then receiver only
    e0 = errors;
    reg_write(15'h004, 32'd3, 4'b0001, 1'b1, aw_acc, w_acc);  // other offset
    check_val("axi_rdata", axi_rdata, 32'd0);
    reg_write(15'h000, 32'd3, 4'b1110, 1'b1, aw_acc, w_acc);  // byte 0 not strobed
    check_val("axi_rdata", axi_rdata, 32'd0);
    reg_write(15'h000, 32'd3, 4'b0001, 1'b0, aw_acc, w_acc);  // port disabled
    check_val("axi_awready", 32'(aw_acc), 32'd0);
    check_val("axi_wready", 32'(w_acc), 32'd0);
    check_val("axi_rdata", axi_rdata, 32'd0);
    reg_write(15'h000, 32'd1, 4'b0001, 1'b1, aw_acc, w_acc);
    check_val("axi_awready", 32'(aw_acc), 32'd1);
    check_val("axi_wready", 32'(w_acc), 32'd1);
    check_val("axi_rdata", axi_rdata, 32'd1);
    end_test("register writes", e0);

    // transmitter stays quiet with only rxen
    e0 = errors;
    repeat (20 * clk_ratio) begin
      @(negedge ioclk);
      check_val("serial_txd", 32'(serial_loop), 32'd0);
      check_val("is_as_tvalid", 32'(is_as_tvalid), 32'd0);
    end
    reg_write(15'h000, 32'd3, 4'b0001, 1'b1, aw_acc, w_acc);
    check_val("axi_rdata", axi_rdata, 32'd3);
    n = 0;
    while (!is_as_tready && n < 40) begin
      @(negedge ioclk);
      n++;
    end
    assert (is_as_tready) else report_error("is_as_tready never rose after txen");
    end_test("transmit gating", e0);

    // loopback with one beat per beat period
    e0 = errors;
    n = 0;
    while (next_idx < num_beats && n < 4 * num_beats) begin
      offer_slot();
      n++;
    end
    assert (next_idx == num_beats) else report_error("stream stalled during loopback");
    @(negedge ioclk);
    as_is_tvalid = 1'b0;
    wait_received(next_idx, 200);
    check_val("received beat count", 32'(rcv_count), 32'(next_idx));
    end_test("loopback ordering", e0);

    // back-pressure from the remote ready
    e0 = errors;
    as_is_tready = 1'b0;
    n = 0;
    while (is_as_tready && n < 20) begin
      offer_slot();
      n++;
    end
    assert (!is_as_tready) else report_error("is_as_tready did not fall with sink stalled");
    mark    = next_idx;
    blocked = 0;
    repeat (8) offer_slot();
    check_val("beats accepted while stalled", 32'(next_idx), 32'(mark));
    check_val("decoy offers", 32'(blocked), 32'd8);
    as_is_tready = 1'b1;
    n = 0;
    while (!is_as_tready && n < 20) begin
      offer_slot();
      n++;
    end
    assert (is_as_tready) else report_error("is_as_tready did not return after stall");
    target = next_idx + 16;
    n = 0;
    while (next_idx < target && n < 64) begin
      offer_slot();
      n++;
    end
    assert (next_idx == target) else report_error("delivery did not resume after stall");
    @(negedge ioclk);
    as_is_tvalid = 1'b0;
    wait_received(next_idx, 200);
    repeat (4 * clk_ratio) @(negedge ioclk);  // room for any stray decoy
    check_val("received beat count", 32'(rcv_count), 32'(next_idx));
    end_test("flow control", e0);

    $display("tests %0d run, %0d failed; %0d checks, %0d errors; beats sent %0d, received %0d",
             tests_run, tests_failed, checks, errors, next_idx, rcv_count);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
serdes_link_pkg.sv
serdes_reg_pkg.sv
serdes_ctrl_regs.sv
serdes_beat_phase.sv
serdes_tx_serializer.sv
serdes_rx_lane.sv
serdes_rx_beat_assemble.sv
io_serdes.sv
tb_io_serdes.sv
